// File: all.f
+incdir+src
src/axi_pkg.sv
src/sram_pkg.sv
src/sram_req_if.sv
src/axi_burst_ctrl.sv
src/sram_byte_array.sv
src/axi_read_return.sv
src/axi_sram_slave.sv
test/axi_sram_properties.sv
test/axi_sram_slave_tb.sv

// File: src/axi_burst_ctrl.sv
`timescale 1ns/1ns
`include "axi_defs.svh"

module axi_burst_ctrl (
	input  logic                        clk,
	input  logic                        rst,

	// write address
	input  logic [`AXI_ID_BITS-1:0]     AWID,
	input  logic [`AXI_ADDR_BITS-1:0]   AWADDR,
	input  logic [`AXI_LEN_BITS-1:0]    AWLEN,
	input  logic [`AXI_SIZE_BITS-1:0]   AWSIZE,
	input  logic [1:0]                  AWBURST,
	input  logic                        AWVALID,
	output logic                        AWREADY,

	// write data
	input  logic [`AXI_DATA_BITS-1:0]   WDATA,
	input  logic [`AXI_STRB_BITS-1:0]   WSTRB,
	input  logic                        WLAST,
	input  logic                        WVALID,
	output logic                        WREADY,

	// write response
	output logic [`AXI_ID_BITS-1:0]     BID,
	output logic [1:0]                  BRESP,
	output logic                        BVALID,
	input  logic                        BREADY,

	// read address
	input  logic [`AXI_ID_BITS-1:0]     ARID,
	input  logic [`AXI_ADDR_BITS-1:0]   ARADDR,
	input  logic [`AXI_LEN_BITS-1:0]    ARLEN,
	input  logic [`AXI_SIZE_BITS-1:0]   ARSIZE,
	input  logic [1:0]                  ARBURST,
	input  logic                        ARVALID,
	output logic                        ARREADY,

	// read return handshake
	input  logic                        ret_free,
	input  logic                        rd_done,
	output logic                        rd_last,
	output logic [`AXI_ID_BITS-1:0]     rid,

	sram_req_if.ctrl                    mem
);

	axi_pkg::burst_state_t      state_q;
	axi_pkg::burst_state_t      state_d;
	axi_pkg::burst_t            burst_q;
	logic [`AXI_ID_BITS-1:0]    id_q;
	logic [`AXI_LEN_BITS-1:0]   len_q;
	logic [`AXI_LEN_BITS-1:0]   cnt_q;
	logic [`SRAM_ADDR_BITS-1:0] addr_q;
	logic                       issued_q;
	logic                       aw_fire;
	logic                       ar_fire;
	logic                       w_fire;
	logic                       b_fire;
	logic                       rd_issue;
	sram_pkg::sram_req_t        req_d;

	// every burst type advances one word, FIXED and WRAP run as INCR
	function automatic logic [`SRAM_ADDR_BITS-1:0] addr_step(input axi_pkg::burst_t b);
		logic [`SRAM_ADDR_BITS-1:0] step;
		case (b)
			axi_pkg::INCR: step = `SRAM_ADDR_BITS'(1);
			default:       step = `SRAM_ADDR_BITS'(1);
		endcase
		return step;
	endfunction

	// address channels, write wins a tie
	assign AWREADY = (state_q == axi_pkg::idle);
	assign ARREADY = (state_q == axi_pkg::idle) && !AWVALID;
	assign aw_fire = AWVALID && AWREADY;
	assign ar_fire = ARVALID && ARREADY;

	assign WREADY  = (state_q == axi_pkg::write_burst);
	assign w_fire  = WVALID && WREADY;

	assign BVALID  = (state_q == axi_pkg::write_resp);
	assign BID     = id_q;
	assign BRESP   = `AXI_RESP_OKAY;
	assign b_fire  = BVALID && BREADY;

	// reads only while the return buffer has room
	assign rd_issue = (state_q == axi_pkg::read_burst) && !issued_q && ret_free;
	assign rd_last  = rd_issue && (cnt_q == len_q);
	assign rid      = id_q;

	always_comb begin
		req_d            = '0;
		req_d.we         = w_fire;
		req_d.addr       = addr_q;
		req_d.wdata.word = WDATA;
		req_d.bmask      = WSTRB;
	end

	assign mem.en  = w_fire || rd_issue;
	assign mem.req = req_d;

	always_comb begin
		state_d = state_q;
		case (state_q)
			axi_pkg::idle: begin
				if (aw_fire)
					state_d = axi_pkg::write_burst;
				else if (ar_fire)
					state_d = axi_pkg::read_burst;
			end
			axi_pkg::write_burst: begin
				if (w_fire && WLAST)
					state_d = axi_pkg::write_resp;
			end
			axi_pkg::write_resp: begin
				if (b_fire)
					state_d = axi_pkg::idle;
			end
			axi_pkg::read_burst: begin
				// leave only once the last beat has gone out on R
				if (rd_done)
					state_d = axi_pkg::idle;
			end
			default: state_d = axi_pkg::idle;
		endcase
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state_q  <= axi_pkg::idle;
			cnt_q    <= '0;
			issued_q <= 1'b0;
		end else begin
			state_q <= state_d;
			if (ar_fire) begin
				cnt_q    <= '0;
				issued_q <= 1'b0;
			end else if (rd_issue) begin
				cnt_q <= cnt_q + 1'b1;
				if (rd_last)
					issued_q <= 1'b1;
			end
		end
	end

	// burst attributes and word address, size is ignored
	always_ff @(posedge clk) begin
		if (aw_fire) begin
			id_q    <= AWID;
			len_q   <= AWLEN;
			addr_q  <= AWADDR[15:2];
			burst_q <= axi_pkg::burst_t'(AWBURST);
		end else if (ar_fire) begin
			id_q    <= ARID;
			len_q   <= ARLEN;
			addr_q  <= ARADDR[15:2];
			burst_q <= axi_pkg::burst_t'(ARBURST);
		end else if (w_fire || rd_issue) begin
			// 14-bit address wraps at the top of the array
			addr_q <= addr_q + addr_step(burst_q);
		end
	end

endmodule

// File: src/axi_defs.svh
`ifndef AXI_DEFS_SVH
`define AXI_DEFS_SVH

// AXI channel widths
`define AXI_ID_BITS    8
`define AXI_ADDR_BITS  32
`define AXI_DATA_BITS  32
`define AXI_LEN_BITS   8
`define AXI_SIZE_BITS  3
`define AXI_STRB_BITS  4

// 16K words of 32 bits
`define SRAM_ADDR_BITS 14

// only response ever returned
`define AXI_RESP_OKAY  2'b00

// read return buffer entries
`define RET_DEPTH      2

`endif

// File: src/axi_pkg.sv
package axi_pkg;

	// burst control FSM
	typedef enum logic [1:0] {
		idle        = 2'b00,
		read_burst  = 2'b01,
		write_burst = 2'b10,
		write_resp  = 2'b11
	} burst_state_t;

	// AxBURST encoding
	typedef enum logic [1:0] {
		FIXED = 2'b00,
		INCR  = 2'b01,
		WRAP  = 2'b10
	} burst_t;

endpackage

// File: src/axi_read_return.sv
`timescale 1ns/1ns
`include "axi_defs.svh"

module axi_read_return (
	input  logic                        clk,
	input  logic                        rst,
	sram_req_if.ret                     mem,
	input  logic                        rd_last,
	input  logic [`AXI_ID_BITS-1:0]     rid,

	// read data channel
	output logic [`AXI_ID_BITS-1:0]     RID,
	output logic [`AXI_DATA_BITS-1:0]   RDATA,
	output logic [1:0]                  RRESP,
	output logic                        RLAST,
	output logic                        RVALID,
	input  logic                        RREADY,

	output logic                        ret_free,
	output logic                        rd_done
);

	// pointers wrap naturally, depth is a power of two
	localparam int PTR_BITS = $clog2(`RET_DEPTH);
	localparam int CNT_BITS = $clog2(`RET_DEPTH + 1);

	sram_pkg::sram_word_u   data_q [`RET_DEPTH];
	logic [`RET_DEPTH-1:0]  last_q;
	logic [PTR_BITS-1:0]    wr_ptr_q;
	logic [PTR_BITS-1:0]    rd_ptr_q;
	logic [CNT_BITS-1:0]    count_q;
	logic                   last_pend_q;
	logic                   empty;
	logic                   r_fire;
	logic                   push;
	logic                   pop;

	assign empty = (count_q == '0);

	// empty buffer lets the array output straight through
	assign RVALID = empty ? mem.rvalid : 1'b1;
	assign RDATA  = empty ? mem.rdata.word : data_q[rd_ptr_q].word;
	assign RLAST  = empty ? last_pend_q : last_q[rd_ptr_q];
	assign RID    = rid;
	assign RRESP  = `AXI_RESP_OKAY;

	assign r_fire  = RVALID && RREADY;
	assign push    = mem.rvalid && !(empty && RREADY);
	assign pop     = r_fire && !empty;
	assign rd_done = r_fire && RLAST;

	// rvalid marks the one read in flight out of the array
	assign ret_free = (count_q + CNT_BITS'(mem.rvalid)) < CNT_BITS'(`RET_DEPTH);

	always_ff @(posedge clk) begin
		if (push) begin
			data_q[wr_ptr_q] <= mem.rdata;
			last_q[wr_ptr_q] <= last_pend_q;
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			wr_ptr_q    <= '0;
			rd_ptr_q    <= '0;
			count_q     <= '0;
			last_pend_q <= 1'b0;
		end else begin
			// last flag lines up with the array's rvalid
			last_pend_q <= rd_last;
			if (push)
				wr_ptr_q <= wr_ptr_q + 1'b1;
			if (pop)
				rd_ptr_q <= rd_ptr_q + 1'b1;
			case ({push, pop})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
		end
	end

endmodule

// File: src/axi_sram_slave.sv
`timescale 1ns/1ns
`include "axi_defs.svh"

module axi_sram_slave (
	input  logic                        clk,
	input  logic                        rst,

	input  logic [`AXI_ID_BITS-1:0]     AWID,
	input  logic [`AXI_ADDR_BITS-1:0]   AWADDR,
	input  logic [`AXI_LEN_BITS-1:0]    AWLEN,
	input  logic [`AXI_SIZE_BITS-1:0]   AWSIZE,
	input  logic [1:0]                  AWBURST,
	input  logic                        AWVALID,
	output logic                        AWREADY,

	input  logic [`AXI_DATA_BITS-1:0]   WDATA,
	input  logic [`AXI_STRB_BITS-1:0]   WSTRB,
	input  logic                        WLAST,
	input  logic                        WVALID,
	output logic                        WREADY,

	output logic [`AXI_ID_BITS-1:0]     BID,
	output logic [1:0]                  BRESP,
	output logic                        BVALID,
	input  logic                        BREADY,

	input  logic [`AXI_ID_BITS-1:0]     ARID,
	input  logic [`AXI_ADDR_BITS-1:0]   ARADDR,
	input  logic [`AXI_LEN_BITS-1:0]    ARLEN,
	input  logic [`AXI_SIZE_BITS-1:0]   ARSIZE,
	input  logic [1:0]                  ARBURST,
	input  logic                        ARVALID,
	output logic                        ARREADY,

	output logic [`AXI_ID_BITS-1:0]     RID,
	output logic [`AXI_DATA_BITS-1:0]   RDATA,
	output logic [1:0]                  RRESP,
	output logic                        RLAST,
	output logic                        RVALID,
	input  logic                        RREADY
);

	logic                    ret_free;
	logic                    rd_done;
	logic                    rd_last;
	logic [`AXI_ID_BITS-1:0] rid;

	sram_req_if mem_if ();

	// stage 1, channel control and address generation
	axi_burst_ctrl axi_burst_ctrl_inst (
		.clk      (clk),
		.rst      (rst),
		.AWID     (AWID),
		.AWADDR   (AWADDR),
		.AWLEN    (AWLEN),
		.AWSIZE   (AWSIZE),
		.AWBURST  (AWBURST),
		.AWVALID  (AWVALID),
		.AWREADY  (AWREADY),
		.WDATA    (WDATA),
		.WSTRB    (WSTRB),
		.WLAST    (WLAST),
		.WVALID   (WVALID),
		.WREADY   (WREADY),
		.BID      (BID),
		.BRESP    (BRESP),
		.BVALID   (BVALID),
		.BREADY   (BREADY),
		.ARID     (ARID),
		.ARADDR   (ARADDR),
		.ARLEN    (ARLEN),
		.ARSIZE   (ARSIZE),
		.ARBURST  (ARBURST),
		.ARVALID  (ARVALID),
		.ARREADY  (ARREADY),
		.ret_free (ret_free),
		.rd_done  (rd_done),
		.rd_last  (rd_last),
		.rid      (rid),
		.mem      (mem_if.ctrl)
	);

	// stage 2
	sram_byte_array sram_byte_array_inst (
		.clk (clk),
		.rst (rst),
		.mem (mem_if.array)
	);

	// stage 3, buffered R channel
	axi_read_return axi_read_return_inst (
		.clk      (clk),
		.rst      (rst),
		.mem      (mem_if.ret),
		.rd_last  (rd_last),
		.rid      (rid),
		.RID      (RID),
		.RDATA    (RDATA),
		.RRESP    (RRESP),
		.RLAST    (RLAST),
		.RVALID   (RVALID),
		.RREADY   (RREADY),
		.ret_free (ret_free),
		.rd_done  (rd_done)
	);

endmodule

// File: src/sram_byte_array.sv
`timescale 1ns/1ns
`include "axi_defs.svh"

module sram_byte_array (
	input  logic       clk,
	input  logic       rst,
	sram_req_if.array  mem
);

	localparam int WORDS = 1 << `SRAM_ADDR_BITS;

	sram_pkg::sram_word_u ram [WORDS];
	logic                 wr_en;
	logic                 rd_en;

	assign wr_en = mem.en && mem.req.we;
	assign rd_en = mem.en && !mem.req.we;

	// byte lanes outside bmask keep their old value
	always_ff @(posedge clk) begin
		if (wr_en) begin
			for (int i = 0; i < `AXI_STRB_BITS; i++) begin
				if (mem.req.bmask[i])
					ram[mem.req.addr].bytes[i] <= mem.req.wdata.bytes[i];
			end
		end
	end

	// registered read port
	always_ff @(posedge clk) begin
		if (rd_en)
			mem.rdata <= ram[mem.req.addr];
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst)
			mem.rvalid <= 1'b0;
		else
			mem.rvalid <= rd_en;
	end

endmodule

// File: src/sram_pkg.sv
`include "axi_defs.svh"

package sram_pkg;

	// one SRAM word, whole or per byte lane
	typedef union packed {
		logic [`AXI_DATA_BITS-1:0]      word;
		logic [`AXI_STRB_BITS-1:0][7:0] bytes;
	} sram_word_u;

	// one access to the array
	typedef struct packed {
		logic                       we;
		logic [`SRAM_ADDR_BITS-1:0] addr;
		sram_word_u                 wdata;
		logic [`AXI_STRB_BITS-1:0]  bmask;
	} sram_req_t;

endpackage

// File: src/sram_req_if.sv
`timescale 1ns/1ns

interface sram_req_if;

	// one access per cycle with en high
	logic                   en;
	sram_pkg::sram_req_t    req;

	// read data, one cycle after the access
	logic                   rvalid;
	sram_pkg::sram_word_u   rdata;

	modport ctrl (
		output en,
		output req
	);

	modport array (
		input  en,
		input  req,
		output rvalid,
		output rdata
	);

	modport ret (
		input  rvalid,
		input  rdata
	);

endinterface

// File: test/axi_sram_properties.sv
`timescale 1ns/1ns
`include "axi_defs.svh"

module axi_sram_properties (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      RVALID,
	input  logic                      RREADY,
	input  logic [`AXI_DATA_BITS-1:0] RDATA,
	input  logic                      BVALID,
	input  logic                      BREADY,
	input  logic                      WREADY
);

	// failed assertions so far
	int fail_count = 0;

	// a stalled R beat keeps its payload
	assert property (@(posedge clk) disable iff (!rst)
		RVALID && !RREADY |=> RVALID && $stable(RDATA))
		else begin
			fail_count++;
			$error("R beat dropped or changed while RREADY was low");
		end

	assert property (@(posedge clk) disable iff (!rst)
		BVALID && !BREADY |=> BVALID)
		else begin
			fail_count++;
			$error("BVALID fell before BREADY");
		end

	// one burst at a time, so write and read data never overlap
	assert property (@(posedge clk) disable iff (!rst)
		!(WREADY && RVALID))
		else begin
			fail_count++;
			$error("WREADY and RVALID high in the same cycle");
		end

	assert property (@(posedge clk) $rose(rst) |-> !RVALID)
		else begin
			fail_count++;
			$error("RVALID high right after reset");
		end

endmodule

bind axi_sram_slave axi_sram_properties axi_sram_properties_inst (
	.clk    (clk),
	.rst    (rst),
	.RVALID (RVALID),
	.RREADY (RREADY),
	.RDATA  (RDATA),
	.BVALID (BVALID),
	.BREADY (BREADY),
	.WREADY (WREADY)
);

// File: test/axi_sram_slave_tb.sv
`timescale 1ns/1ns
`include "axi_defs.svh"

module axi_sram_slave_tb;

	localparam int TIMEOUT = 200;
	localparam int WORDS = 1 << `SRAM_ADDR_BITS;

	logic clk;
	logic rst;
	logic [`AXI_ID_BITS-1:0] AWID, ARID, BID, RID;
	logic [`AXI_ADDR_BITS-1:0] AWADDR, ARADDR;
	logic [`AXI_LEN_BITS-1:0] AWLEN, ARLEN;
	logic [`AXI_SIZE_BITS-1:0] AWSIZE, ARSIZE;
	logic [1:0] AWBURST, ARBURST, BRESP, RRESP;
	logic AWVALID, AWREADY, WLAST, WVALID, WREADY, BVALID, BREADY;
	logic ARVALID, ARREADY, RLAST, RVALID, RREADY;
	logic [`AXI_DATA_BITS-1:0] WDATA, RDATA;
	logic [`AXI_STRB_BITS-1:0] WSTRB;

	// reference copy of the SRAM contents
	sram_pkg::sram_word_u model [WORDS];
	logic [31:0] rng = 32'h81e;
	logic [1:0] burst_kind = axi_pkg::INCR;
	logic [31:0] wdata_q [$];
	logic [3:0] wstrb_q [$];
	int b_count = 0;
	int ar_count = 0;

	axi_sram_slave axi_sram_slave_inst (.*);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		if (BVALID && BREADY)
			b_count <= b_count + 1;
		if (ARVALID && ARREADY)
			ar_count <= ar_count + 1;
	end

	// a bound handshake assertion has failed
	always @(posedge clk) begin
		if (axi_sram_slave_inst.axi_sram_properties_inst.fail_count != 0)
			report_error("an AXI handshake assertion in the bound checker failed");
	end

	function automatic logic [31:0] xorshift32();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	// strobed byte lanes take the new data, the rest keep the old word
	function automatic sram_pkg::sram_word_u merge_bytes(input sram_pkg::sram_word_u old,
			input logic [31:0] data, input logic [3:0] strb);
		sram_pkg::sram_word_u nw;
		sram_pkg::sram_word_u res;
		nw.word = data;
		res = old;
		for (int i = 0; i < 4; i++)
			if (strb[i])
				res.bytes[i] = nw.bytes[i];
		return res;
	endfunction

	task automatic report_error(input string what);
		$display("%s", what);
		$display("Simulation failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp)
			else report_error($sformatf("FAILED %s expected %h got %h", name, exp, act));
	endtask

	task automatic fill_random(input int beats, input bit full_strobe);
		logic [31:0] r;
		wdata_q = {};
		wstrb_q = {};
		for (int i = 0; i < beats; i++) begin
			wdata_q.push_back(xorshift32());
			r = xorshift32();
			wstrb_q.push_back(full_strobe ? 4'hf : r[3:0]);
		end
	endtask

	task automatic axi_write(input logic [7:0] id, input logic [13:0] waddr, input int len);
		int n = 0;
		logic [13:0] a;
		AWID = id;
		AWADDR = {16'h0, waddr, 2'b00};
		AWLEN = len[7:0];
		AWBURST = burst_kind;
		AWVALID = 1'b1;
		do begin
			@(posedge clk);
			if (++n > TIMEOUT)
				report_error("timeout waiting for AWREADY");
		end while (!AWREADY);
		@(negedge clk);
		AWVALID = 1'b0;
		for (int i = 0; i <= len; i++) begin
			WDATA = wdata_q[i];
			WSTRB = wstrb_q[i];
			WLAST = (i == len);
			WVALID = 1'b1;
			n = 0;
			do begin
				@(posedge clk);
				if (++n > TIMEOUT)
					report_error("timeout waiting for WREADY");
			end while (!WREADY);
			// first beat right after AW, the others back to back
			check_value("WREADY delay", 1, n);
			a = waddr + 14'(i);
			model[a] = merge_bytes(model[a], wdata_q[i], wstrb_q[i]);
			@(negedge clk);
		end
		WVALID = 1'b0;
		WLAST = 1'b0;
		BREADY = 1'b1;
		n = 0;
		do begin
			@(posedge clk);
			if (++n > TIMEOUT)
				report_error("timeout waiting for BVALID");
		end while (!BVALID);
		check_value("BVALID delay", 1, n);
		check_value("BID", id, BID);
		check_value("BRESP", `AXI_RESP_OKAY, BRESP);
		@(negedge clk);
		BREADY = 1'b0;
	endtask

	task automatic start_ar(input logic [7:0] id, input logic [13:0] waddr, input int len);
		ARID = id;
		ARADDR = {16'h0, waddr, 2'b00};
		ARLEN = len[7:0];
		ARBURST = burst_kind;
		ARVALID = 1'b1;
	endtask

	task automatic finish_ar();
		int n = 0;
		do begin
			@(posedge clk);
			if (++n > TIMEOUT)
				report_error("timeout waiting for ARREADY");
		end while (!ARREADY);
		@(negedge clk);
		ARVALID = 1'b0;
	endtask

	// collects len+1 beats, optionally with a random RREADY
	task automatic recv_r(input logic [7:0] id, input logic [13:0] waddr, input int len,
			input bit random_ready, input bit back_to_back);
		int beat = 0;
		int n = 0;
		logic [31:0] r;
		logic [13:0] a;
		while (beat <= len) begin
			if (random_ready) begin
				r = xorshift32();
				RREADY = r[0];
			end else
				RREADY = 1'b1;
			@(posedge clk);
			n++;
			if (RVALID && RREADY) begin
				a = waddr + 14'(beat);
				check_value("RDATA", model[a].word, RDATA);
				check_value("RID", id, RID);
				check_value("RRESP", `AXI_RESP_OKAY, RRESP);
				check_value("RLAST", beat == len, RLAST);
				if (back_to_back)
					check_value("RVALID delay", (beat == 0) ? 2 : 1, n);
				beat++;
				n = 0;
			end else if (n > TIMEOUT)
				report_error("timeout waiting for a read beat");
			@(negedge clk);
		end
		RREADY = 1'b0;
		// no extra beat after RLAST
		@(posedge clk);
		check_value("RVALID", 0, RVALID);
		@(negedge clk);
	endtask

	task automatic axi_read(input logic [7:0] id, input logic [13:0] waddr, input int len,
			input bit random_ready, input bit back_to_back);
		start_ar(id, waddr, len);
		finish_ar();
		recv_r(id, waddr, len, random_ready, back_to_back);
	endtask

	task automatic test_reset_single();
		logic [31:0] r;
		check_value("AWREADY", 1, AWREADY);
		check_value("ARREADY", 1, ARREADY);
		check_value("RVALID", 0, RVALID);
		check_value("WREADY", 0, WREADY);
		check_value("BVALID", 0, BVALID);
		r = xorshift32();
		fill_random(1, 1);
		axi_write(8'h3c, r[13:0], 0);
		axi_read(8'h5a, r[13:0], 0, 0, 0);
	endtask

	task automatic test_burst();
		logic [31:0] r;
		int b0;
		r = xorshift32();
		b0 = b_count;
		fill_random(8, 1);
		axi_write(8'h11, r[13:0], 7);
		// BREADY stays high so a second response would be counted
		BREADY = 1'b1;
		axi_read(8'h12, r[13:0], 7, 0, 0);
		BREADY = 1'b0;
		check_value("B count", b0 + 1, b_count);
	endtask

	task automatic test_strobes();
		logic [31:0] r;
		r = xorshift32();
		fill_random(8, 1);
		axi_write(8'h21, r[13:0], 7);
		fill_random(8, 0);
		wstrb_q[0] = 4'h0;
		wstrb_q[1] = 4'h1;
		wstrb_q[2] = 4'h2;
		wstrb_q[3] = 4'h4;
		wstrb_q[4] = 4'h8;
		axi_write(8'h22, r[13:0], 7);
		axi_read(8'h23, r[13:0], 7, 0, 0);
	endtask

	task automatic test_backpressure();
		logic [31:0] r;
		r = xorshift32();
		fill_random(16, 1);
		axi_write(8'h31, r[13:0], 15);
		axi_read(8'h32, r[13:0], 15, 1, 0);
		axi_read(8'h33, r[13:0], 15, 0, 1);
	endtask

	// AW and AR raised together, the write goes first
	task automatic test_priority();
		logic [31:0] r;
		int a0;
		r = xorshift32();
		a0 = ar_count;
		fill_random(4, 1);
		start_ar(8'h42, r[13:0], 3);
		axi_write(8'h41, r[13:0], 3);
		check_value("AR count", a0, ar_count);
		finish_ar();
		recv_r(8'h42, r[13:0], 3, 0, 0);
	endtask

	task automatic test_wrap();
		burst_kind = axi_pkg::WRAP;
		fill_random(4, 1);
		axi_write(8'h51, 14'h3fff, 3);
		axi_read(8'h52, 14'h3fff, 3, 0, 0);
		burst_kind = axi_pkg::INCR;
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b0;
		{AWID, AWADDR, AWLEN, AWBURST, AWVALID} = '0;
		{ARID, ARADDR, ARLEN, ARBURST, ARVALID} = '0;
		AWSIZE = 3'd2;
		ARSIZE = 3'd2;
		{WDATA, WSTRB, WLAST, WVALID} = '0;
		BREADY = 1'b0;
		RREADY = 1'b0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b1;
		@(negedge clk);
		test_reset_single();
		test_burst();
		test_strobes();
		test_backpressure();
		test_priority();
		test_wrap();
		if (axi_sram_slave_inst.axi_sram_properties_inst.fail_count == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule
